//--- verilog/ringsensePkg.sv
package ringsensePkg;

    localparam int NumChan      = 25;
    localparam int ChanW        = 5;
    localparam int CountW       = 24;
    localparam int NodeIdW      = 5;
    localparam int SettleCycles = 10;  // Idle cycles ahead of every head flit.
    localparam int FifoDepth    = 8;

    localparam logic [1:0] FLIT_HEAD = 2'b00;
    localparam logic [1:0] FLIT_BODY = 2'b01;
    localparam logic [1:0] FLIT_TAIL = 2'b11;

    // Sensor node FSM codes.
    localparam logic [1:0] NODE_IDLE = 2'b00;
    localparam logic [1:0] NODE_HEAD = 2'b01;
    localparam logic [1:0] NODE_BODY = 2'b10;
    localparam logic [1:0] NODE_TAIL = 2'b11;

    typedef struct packed {
        logic              group;
        logic [ChanW-1:0]  chan;
        logic [CountW-1:0] count;
    } sampleT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flit views, kind always on top.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [1:0]         kind;
        logic               spare;
        logic [18:0]        rsvd;
        logic [NodeIdW-1:0] node;
        logic [ChanW-1:0]   chan;
    } headT;

    typedef struct packed {
        logic [1:0]  kind;
        logic [13:0] rsvd;
        logic [15:0] countHi;  // Count bits 23..8.
    } bodyT;

    typedef struct packed {
        logic [1:0]  kind;
        logic [21:0] rsvd;
        logic [7:0]  countLo;
    } tailT;

    typedef union packed {
        headT head;
        bodyT body;
        tailT tail;
    } flitT;

endpackage

//--- verilog/sampleBank.sv
`timescale 1ns/100ps

module sampleBank #(
    parameter logic [ringsensePkg::NodeIdW-1:0] NodeId = '0
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            sampleValid_i,
    input  ringsensePkg::sampleT            sample_i,
    input  logic [ringsensePkg::ChanW-1:0]  readChan_i,
    output logic [ringsensePkg::CountW-1:0] readCount_o
);

    logic [ringsensePkg::CountW-1:0] countMem [ringsensePkg::NumChan];

    logic groupHit;
    logic writeChanOk;
    logic readChanOk;
    logic writeEn;

    // Group bit widened against the node id.
    assign groupHit = {{(ringsensePkg::NodeIdW-1){1'b0}}, sample_i.group} == NodeId;

    assign writeChanOk = int'(sample_i.chan) < ringsensePkg::NumChan;
    assign readChanOk  = int'(readChan_i) < ringsensePkg::NumChan;
    assign writeEn     = sampleValid_i & groupHit & writeChanOk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Count registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ringsensePkg::NumChan; i++) begin
                countMem[i] <= '0;
            end
        end else if (writeEn) begin
            countMem[sample_i.chan] <= sample_i.count;
        end
    end

    // Unused channel codes read back as zero.
    assign readCount_o = readChanOk ? countMem[readChan_i] : '0;

endmodule

//--- verilog/sensorNode.sv
`timescale 1ns/100ps

module sensorNode #(
    parameter logic [ringsensePkg::NodeIdW-1:0] NodeId = '0
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            startPulse_i,
    output logic [ringsensePkg::ChanW-1:0]  readChan_o,
    input  logic [ringsensePkg::CountW-1:0] readCount_i,
    output logic                            flitValid_o,
    input  logic                            flitReady_i,
    output ringsensePkg::flitT              flit_o,
    output logic                            sweepDone_o
);

    logic                                       armed;
    logic [1:0]                                 state;
    logic [1:0]                                 stateNxt;
    logic [$clog2(ringsensePkg::SettleCycles+1)-1:0] settleCnt;
    logic [ringsensePkg::ChanW-1:0]             chan;
    logic [ringsensePkg::CountW-1:0]            countQ;

    logic settleDone;
    logic lastChan;
    logic tailXfer;

    assign settleDone = int'(settleCnt) == ringsensePkg::SettleCycles - 1;
    assign lastChan   = int'(chan) == ringsensePkg::NumChan - 1;
    assign tailXfer   = (state == ringsensePkg::NODE_TAIL) & flitReady_i;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            armed <= 1'b0;
        end else if (!armed) begin
            armed <= startPulse_i;  // Only an idle node arms.
        end else if (tailXfer & lastChan) begin
            armed <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        stateNxt = state;
        case (state)
            ringsensePkg::NODE_IDLE: if (armed & settleDone) stateNxt = ringsensePkg::NODE_HEAD;
            ringsensePkg::NODE_HEAD: if (flitReady_i) stateNxt = ringsensePkg::NODE_BODY;
            ringsensePkg::NODE_BODY: if (flitReady_i) stateNxt = ringsensePkg::NODE_TAIL;
            default:                 if (flitReady_i) stateNxt = ringsensePkg::NODE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ringsensePkg::NODE_IDLE;
            settleCnt <= '0;
            chan      <= '0;
        end else begin
            state <= stateNxt;
            if (armed & (state == ringsensePkg::NODE_IDLE) & !settleDone) begin
                settleCnt <= settleCnt + 1'b1;
            end else begin
                settleCnt <= '0;
            end
            if (tailXfer) begin
                chan <= lastChan ? '0 : chan + 1'b1;
            end
        end
    end

    // Body and tail come from one snapshot.
    always_ff @(posedge clk) begin
        if (armed & (state == ringsensePkg::NODE_IDLE) & settleDone) begin
            countQ <= readCount_i;
        end
    end

    always_comb begin
        flit_o = '0;
        case (state)
            ringsensePkg::NODE_HEAD: begin
                flit_o.head.kind = ringsensePkg::FLIT_HEAD;
                flit_o.head.node = NodeId;
                flit_o.head.chan = chan;
            end
            ringsensePkg::NODE_BODY: begin
                flit_o.body.kind    = ringsensePkg::FLIT_BODY;
                flit_o.body.countHi = countQ[ringsensePkg::CountW-1:8];
            end
            ringsensePkg::NODE_TAIL: begin
                flit_o.tail.kind    = ringsensePkg::FLIT_TAIL;
                flit_o.tail.countLo = countQ[7:0];
            end
            default: flit_o = '0;
        endcase
    end

    assign readChan_o  = chan;
    assign flitValid_o = state != ringsensePkg::NODE_IDLE;
    assign sweepDone_o = tailXfer & lastChan;  // Last tail accepted.

endmodule

//--- verilog/flitMerge.sv
`timescale 1ns/100ps

module flitMerge (
    input  logic               clk,
    input  logic               rstn,
    input  logic               aValid_i,
    output logic               aReady_o,
    input  ringsensePkg::flitT aFlit_i,
    input  logic               bValid_i,
    output logic               bReady_o,
    input  ringsensePkg::flitT bFlit_i,
    output logic               outValid_o,
    input  logic               outReady_i,
    output ringsensePkg::flitT outFlit_o
);

    ringsensePkg::flitT fifoMem [ringsensePkg::FifoDepth];

    logic [$clog2(ringsensePkg::FifoDepth)-1:0]   wrPtr;
    logic [$clog2(ringsensePkg::FifoDepth)-1:0]   rdPtr;
    logic [$clog2(ringsensePkg::FifoDepth+1)-1:0] fill;

    logic               locked;
    logic               lockB;
    logic               lastB;
    logic               aHead;
    logic               bHead;
    logic               grantB;
    logic               grantAny;
    logic               full;
    logic               push;
    logic               pop;
    ringsensePkg::flitT inFlit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet lock arbitration.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign aHead = aValid_i & (aFlit_i.head.kind == ringsensePkg::FLIT_HEAD);
    assign bHead = bValid_i & (bFlit_i.head.kind == ringsensePkg::FLIT_HEAD);

    // Alternate on a tie.
    assign grantB   = locked ? lockB : (bHead & (!aHead | !lastB));
    assign grantAny = locked | aHead | bHead;
    assign full     = int'(fill) == ringsensePkg::FifoDepth;

    assign aReady_o = grantAny & !grantB & !full;
    assign bReady_o = grantAny & grantB & !full;

    assign inFlit = grantB ? bFlit_i : aFlit_i;
    assign push   = (aValid_i & aReady_o) | (bValid_i & bReady_o);
    assign pop    = outValid_o & outReady_i;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            locked <= 1'b0;
            lockB  <= 1'b0;
            lastB  <= 1'b1;  // Source a wins the first tie.
        end else if (push) begin
            if (inFlit.tail.kind == ringsensePkg::FLIT_TAIL) begin
                locked <= 1'b0;
            end else if (inFlit.head.kind == ringsensePkg::FLIT_HEAD) begin
                locked <= 1'b1;
                lockB  <= grantB;
                lastB  <= grantB;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output FIFO.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (push) wrPtr <= (int'(wrPtr) == ringsensePkg::FifoDepth - 1) ? '0 : wrPtr + 1'b1;
            if (pop) rdPtr <= (int'(rdPtr) == ringsensePkg::FifoDepth - 1) ? '0 : rdPtr + 1'b1;
            if (push & !pop) begin
                fill <= fill + 1'b1;
            end else if (pop & !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) fifoMem[wrPtr] <= inFlit;
    end

    assign outValid_o = fill != '0;
    assign outFlit_o  = fifoMem[rdPtr];

endmodule

//--- verilog/ringsenseTop.sv
`timescale 1ns/100ps

module ringsenseTop (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 sampleValid_i,
    input  ringsensePkg::sampleT sample_i,
    input  logic                 startPulse_i,
    output logic                 outValid_o,
    input  logic                 outReady_i,
    output ringsensePkg::flitT   outFlit_o,
    output logic [1:0]           sweepDone_o
);

    logic [ringsensePkg::ChanW-1:0]  readChan  [2];
    logic [ringsensePkg::CountW-1:0] readCount [2];
    logic                            flitValid [2];
    logic                            flitReady [2];
    ringsensePkg::flitT              flit      [2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One bank and node per group.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < 2; g++) begin : grp
        sampleBank #(
            .NodeId(ringsensePkg::NodeIdW'(g))
        ) bank_i (
            .clk          (clk),
            .rstn         (rstn),
            .sampleValid_i(sampleValid_i),
            .sample_i     (sample_i),
            .readChan_i   (readChan[g]),
            .readCount_o  (readCount[g])
        );

        sensorNode #(
            .NodeId(ringsensePkg::NodeIdW'(g))
        ) node_i (
            .clk         (clk),
            .rstn        (rstn),
            .startPulse_i(startPulse_i),  // Both nodes start together.
            .readChan_o  (readChan[g]),
            .readCount_i (readCount[g]),
            .flitValid_o (flitValid[g]),
            .flitReady_i (flitReady[g]),
            .flit_o      (flit[g]),
            .sweepDone_o (sweepDone_o[g])
        );
    end

    flitMerge merge_i (
        .clk       (clk),
        .rstn      (rstn),
        .aValid_i  (flitValid[0]),
        .aReady_o  (flitReady[0]),
        .aFlit_i   (flit[0]),
        .bValid_i  (flitValid[1]),
        .bReady_o  (flitReady[1]),
        .bFlit_i   (flit[1]),
        .outValid_o(outValid_o),
        .outReady_i(outReady_i),
        .outFlit_o (outFlit_o)
    );

endmodule

//--- tests/ringsenseVectors.svh
`ifndef RINGSENSE_VECTORS_SVH
`define RINGSENSE_VECTORS_SVH

// Columns are group, channel and 24-bit count.
// Channels never written keep the reset value of zero.
localparam int LoadCount      = 20;
localparam int OverwriteCount = 8;

localparam ringsensePkg::sampleT LoadRows [LoadCount] = '{
    '{1'b0, 5'd0,  24'h13a5c7},
    '{1'b0, 5'd1,  24'h00ff01},
    '{1'b0, 5'd2,  24'h7e0042},
    '{1'b0, 5'd3,  24'h800000},
    '{1'b0, 5'd7,  24'h0a0b0c},
    '{1'b0, 5'd12, 24'hfedcba},
    '{1'b0, 5'd12, 24'h123456},  // Later write wins.
    '{1'b0, 5'd18, 24'h000100},
    '{1'b0, 5'd23, 24'h5a5a5a},
    '{1'b0, 5'd24, 24'hffffff},
    '{1'b1, 5'd0,  24'h2468ac},
    '{1'b1, 5'd1,  24'h000001},
    '{1'b1, 5'd4,  24'h3c3c3c},
    '{1'b1, 5'd5,  24'hc0ffee},
    '{1'b1, 5'd9,  24'h0000ff},
    '{1'b1, 5'd13, 24'h9abcde},
    '{1'b1, 5'd16, 24'h00ff00},
    '{1'b1, 5'd20, 24'h777777},
    '{1'b1, 5'd22, 24'h010203},
    '{1'b1, 5'd24, 24'habcdef}
};

// Second round overwrites.
localparam ringsensePkg::sampleT OverwriteRows [OverwriteCount] = '{
    '{1'b0, 5'd0,  24'h000000},
    '{1'b0, 5'd3,  24'h7fffff},
    '{1'b0, 5'd12, 24'h654321},
    '{1'b0, 5'd24, 24'h0f0f0f},
    '{1'b1, 5'd1,  24'hfffffe},
    '{1'b1, 5'd4,  24'h111111},
    '{1'b1, 5'd11, 24'h5e5e5e},
    '{1'b1, 5'd24, 24'h00abcd}
};

`endif

//--- tests/ringsenseTb.sv
`timescale 1ns/100ps

module ringsenseTb;

    `include "ringsenseVectors.svh"

    localparam int FirstLimit = 100;
    localparam int SweepLimit = 6000;

    logic                 clk;
    logic                 rstn;
    logic                 sampleValid;
    ringsensePkg::sampleT sample;
    logic                 startPulse;
    logic                 outValid;
    logic                 outReady = 1'b1;
    ringsensePkg::flitT   outFlit;
    logic [1:0]           sweepDone;

    logic [ringsensePkg::CountW-1:0] expCount [2][ringsensePkg::NumChan];
    int     pktSeen [2];
    int     flitsSeen [2];
    int     nextChan [2];
    int     doneCount [2];
    int     errorCount;
    int     timeoutCount;
    logic   idleCheck;
    logic   randomReady;
    integer seed = 32'h289d_1e8d;

    ringsenseTop dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .sampleValid_i(sampleValid),
        .sample_i     (sample),
        .startPulse_i (startPulse),
        .outValid_o   (outValid),
        .outReady_i   (outReady),
        .outFlit_o    (outFlit),
        .sweepDone_o  (sweepDone)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (randomReady) outReady <= 1'($random(seed));  // Random stalls.
        else outReady <= 1'b1;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic watchOutput();
        int                              phase;
        int                              node;
        int                              chanNum;
        int                              pending;
        logic [15:0]                     countHi;
        logic [ringsensePkg::CountW-1:0] count;
        phase = 0;
        node = 0;
        chanNum = 0;
        countHi = '0;
        forever begin
            @(posedge clk);
            if (idleCheck) begin
                checkValue("outValid_o", 32'(outValid), 32'(0));
                checkValue("sweepDone_o", 32'(sweepDone), 32'(0));
            end
            if (rstn && outValid && outReady) begin
                case (phase)
                    0: begin
                        checkValue("head kind", 32'(outFlit.head.kind),
                                   32'(ringsensePkg::FLIT_HEAD));
                        node = int'(outFlit.head.node);
                        chanNum = int'(outFlit.head.chan);
                        if (node > 1) begin
                            errorCount++;
                            $display("Head flit at %0t names unknown node %0d", $time, node);
                            node = node & 1;
                        end
                        checkValue($sformatf("head chan of node %0d", node), 32'(chanNum),
                                   32'(nextChan[node]));
                    end
                    1: begin
                        checkValue("body kind", 32'(outFlit.body.kind),
                                   32'(ringsensePkg::FLIT_BODY));
                        countHi = outFlit.body.countHi;
                    end
                    default: begin
                        checkValue("tail kind", 32'(outFlit.tail.kind),
                                   32'(ringsensePkg::FLIT_TAIL));
                        count = {countHi, outFlit.tail.countLo};  // Reassembled.
                        checkValue($sformatf("count g%0d ch%0d", node, chanNum), 32'(count),
                                   32'(expCount[node][chanNum]));
                        nextChan[node] = (nextChan[node] + 1) % ringsensePkg::NumChan;
                        pktSeen[node]++;
                    end
                endcase
                flitsSeen[node]++;
                phase = (phase + 1) % 3;
            end
            // All flits are in the FIFO by now.
            for (int g = 0; g < 2; g++) begin
                if (sweepDone[g]) begin
                    doneCount[g]++;
                    pending = 3 * ringsensePkg::NumChan * doneCount[g] - flitsSeen[g];
                    if (pending > ringsensePkg::FifoDepth) begin
                        errorCount++;
                        $display("sweepDone_o[%0d] pulsed at %0t with %0d flits still missing",
                                 g, $time, pending);
                    end
                end
            end
        end
    endtask

    task automatic writeSample(input ringsensePkg::sampleT row);
        @(posedge clk);
        sampleValid <= 1'b1;
        sample      <= row;
        expCount[row.group][row.chan] = row.count;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        startPulse <= 1'b1;
        @(posedge clk);
        startPulse <= 1'b0;
    endtask

    task automatic waitFirstFlit(output int cycles, output bit ok);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!outValid && cycles < FirstLimit);
        ok = outValid;
        if (!ok) begin
            timeoutCount++;
            $display("Timeout: no output flit within %0d cycles of start", FirstLimit);
        end
    endtask

    task automatic waitSweepEnd(input int target, output bit ok);
        int cycles;
        cycles = 0;
        while ((pktSeen[0] < target || pktSeen[1] < target) && cycles < SweepLimit) begin
            @(posedge clk);
            cycles++;
        end
        ok = pktSeen[0] >= target && pktSeen[1] >= target;
        if (!ok) begin
            timeoutCount++;
            $display("Timeout: sweep stalled with %0d and %0d packets seen",
                     pktSeen[0], pktSeen[1]);
        end
    endtask

    // No stray traffic after a sweep.
    task automatic checkQuiet(input int round);
        for (int i = 0; i < 4 * ringsensePkg::SettleCycles; i++) begin
            @(posedge clk);
            checkValue("outValid_o", 32'(outValid), 32'(0));
        end
        for (int g = 0; g < 2; g++) begin
            checkValue($sformatf("packets of node %0d", g), 32'(pktSeen[g]),
                       32'(round * ringsensePkg::NumChan));
            checkValue($sformatf("sweepDone_o[%0d] pulses", g), 32'(doneCount[g]), 32'(round));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic runTest();
        bit ok;
        int latency;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (6) @(posedge clk);
        for (int i = 0; i < LoadCount; i++) begin
            writeSample(LoadRows[i]);
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        repeat (4) @(posedge clk);

        pulseStart();
        idleCheck <= 1'b0;
        waitFirstFlit(latency, ok);
        if (!ok) return;
        if (latency < ringsensePkg::SettleCycles + 2) begin
            errorCount++;
            $display("First flit came %0d cycles after start, too early", latency);
        end
        pulseStart();  // Mid-sweep start, must be ignored.
        waitSweepEnd(ringsensePkg::NumChan, ok);
        if (!ok) return;
        checkQuiet(1);

        for (int i = 0; i < OverwriteCount; i++) begin
            writeSample(OverwriteRows[i]);
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        randomReady <= 1'b1;
        pulseStart();
        waitSweepEnd(2 * ringsensePkg::NumChan, ok);
        if (!ok) return;
        checkQuiet(2);
        randomReady <= 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        sampleValid  = 1'b0;
        sample       = '0;
        startPulse   = 1'b0;
        idleCheck    = 1'b1;
        randomReady  = 1'b0;
        errorCount   = 0;
        timeoutCount = 0;
        for (int g = 0; g < 2; g++) begin
            pktSeen[g]   = 0;
            flitsSeen[g] = 0;
            nextChan[g]  = 0;
            doneCount[g] = 0;
            for (int c = 0; c < ringsensePkg::NumChan; c++) begin
                expCount[g][c] = '0;  // Bank reset value.
            end
        end
        fork
            watchOutput();
        join_none
        runTest();
        $display("Finished with %0d errors and %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- ringsense.f
+incdir+tests
verilog/ringsensePkg.sv
verilog/sampleBank.sv
verilog/sensorNode.sv
verilog/flitMerge.sv
verilog/ringsenseTop.sv
tests/ringsenseTb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := ringsenseTb
FILELIST   := ringsense.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
